//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - common/fetch_pkg.sv
  - common/fetch_rsp_if.sv
  - logic/pc_gen.sv
  - axi_fetch/axi_fetch.sv
  - logic/inst_queue.sv
  - logic/predecode.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_fetch.sv

//--- all.f
common/fetch_pkg.sv
common/fetch_rsp_if.sv
logic/pc_gen.sv
axi_fetch/axi_fetch.sv
logic/inst_queue.sv
logic/predecode.sv
logic/fetch_top.sv
bench/tb_clock.sv
bench/tb_fetch.sv

//--- axi_fetch/axi_fetch.sv
`timescale 1ns/1ns

module axi_fetch (
    input  logic                 clock,
    input  logic                 reset,
    // request from pc_gen
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  fetch_pkg::addr_t     req_addr_i,
    input  logic                 flush_i,       // drops the wrong-path read
    // axi read address channel
    output logic                 ar_valid_o,
    input  logic                 ar_ready_i,
    output fetch_pkg::addr_t     ar_addr_o,
    // axi read data channel
    input  logic                 r_valid_i,
    output logic                 r_ready_o,
    input  fetch_pkg::inst_t     r_data_i,
    input  fetch_pkg::axi_resp_t r_resp_i,
    // fetched word toward the queue
    fetch_rsp_if.producer        rsp
);
    import fetch_pkg::*;

    fetch_state_e state_q, state_d;
    logic         stale_q;    // in-flight read belongs to the old path
    addr_t        addr_q;     // pc of the read
    inst_t        data_q;     // returned word
    logic         err_q;      // non-OKAY response

    logic req_fire;
    logic r_fire;

    assign req_fire = req_valid_i && req_ready_o;
    assign r_fire   = r_valid_i && r_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (req_valid_i) state_d = ST_AR;
            ST_AR:   if (ar_ready_i)  state_d = ST_R;
            ST_R: begin
                // a stale beat completes on the bus and is then thrown away
                if (r_valid_i) state_d = (stale_q || flush_i) ? ST_IDLE : ST_HOLD;
            end
            ST_HOLD: if (rsp.ready || flush_i) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // mark a read stale if flush lands before its data returns
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            stale_q <= 1'b0;
        end else if (r_fire) begin
            stale_q <= 1'b0;                // cleared once the beat is taken
        end else if (flush_i && (state_q == ST_AR || state_q == ST_R || req_fire)) begin
            stale_q <= 1'b1;
        end
    end

    // payload capture
    always_ff @(posedge clock) begin
        if (req_fire) begin
            addr_q <= req_addr_i;
        end
        if (r_fire) begin
            data_q <= r_data_i;
            err_q  <= (r_resp_i != 2'b00);
        end
    end

    assign req_ready_o = (state_q == ST_IDLE);  // one read outstanding
    assign ar_valid_o  = (state_q == ST_AR);
    assign ar_addr_o   = addr_q;
    assign r_ready_o   = (state_q == ST_R);

    assign rsp.valid = (state_q == ST_HOLD);
    assign rsp.pc    = addr_q;
    assign rsp.inst  = data_q;
    assign rsp.err   = err_q;

    // AR address frozen until the slave takes it
    property p_ar_stable;
        @(posedge clock) disable iff (!reset)
            ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o);
    endproperty
    a_ar_stable: assert property (p_ar_stable)
        else $error("axi_fetch: AR address changed before handshake");

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 100,   // ns
    parameter int RESET_CYCLES = 4
) (
    output logic clock_o,
    output logic reset_o    // active low
);

    initial begin
        clock_o = 1'b0;
        forever #(PERIOD / 2) clock_o = ~clock_o;
    end

    // release lands on a falling edge, half a period before the next rise
    initial begin
        reset_o = 1'b0;
        #(PERIOD * RESET_CYCLES);
        reset_o = 1'b1;
    end

endmodule

//--- bench/tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch;
    import fetch_pkg::*;

    localparam addr_t RESET_PC    = 32'h8000_0000;
    localparam int    QUEUE_DEPTH = 4;
    localparam int    PROG_WORDS  = 64;                  // program table size
    localparam addr_t FAULT_PC    = RESET_PC + 32'd132;  // word 33 answers SLVERR
    localparam int    WAIT_LIMIT  = 100;                 // cycles without an output
    localparam int    SEED        = 41425;

    logic       clock;
    logic       reset;
    logic       ar_valid;
    logic       ar_ready;
    addr_t      ar_addr;
    logic       r_valid;
    logic       r_ready;
    inst_t      r_data;
    axi_resp_t  r_resp;
    logic       inst_valid;
    logic       inst_ready;
    addr_t      inst_pc;
    inst_t      inst_word;
    logic       inst_err;
    inst_kind_e inst_kind;

    inst_t      prog  [PROG_WORDS];
    inst_kind_e kinds [PROG_WORDS];   // kind the opcode stands for
    int         jumps [PROG_WORDS];   // jal offset in bytes

    addr_t exp_pc;                // model pc of the next output
    int    errors    = 0;
    int    seen      = 0;         // outputs checked
    int    reads     = 0;         // AR handshakes
    int    tests     = 0;
    bit    budget_on = 1'b1;      // no flush yet, so reads track outputs
    int    max_delay = 0;         // slave delay upper bound
    logic  busy      = 1'b0;      // slave owes a data beat
    addr_t rd_addr;
    int    a_wait    = 0;
    int    r_wait    = 0;

    tb_clock #(.PERIOD(100), .RESET_CYCLES(4)) u_clock (.clock_o(clock), .reset_o(reset));

    fetch_top #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(QUEUE_DEPTH)) dut (
        .clock        (clock),
        .reset        (reset),
        .ar_valid_o   (ar_valid),
        .ar_ready_i   (ar_ready),
        .ar_addr_o    (ar_addr),
        .r_valid_i    (r_valid),
        .r_ready_o    (r_ready),
        .r_data_i     (r_data),
        .r_resp_i     (r_resp),
        .inst_valid_o (inst_valid),
        .inst_ready_i (inst_ready),
        .inst_pc_o    (inst_pc),
        .inst_o       (inst_word),
        .inst_err_o   (inst_err),
        .inst_kind_o  (inst_kind)
    );

    // outside the table, an addi whose upper bits hash the whole address
    function automatic inst_t fill_word(input addr_t a);
        return {a[31:7] ^ a[24:0], 7'b0010011};
    endfunction

    function automatic inst_t jal_word(input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};  // rd = x0
    endfunction

    function automatic bit in_table(input addr_t a);
        return (a - RESET_PC) < addr_t'(4 * PROG_WORDS);   // wraps below the base
    endfunction

    function automatic inst_t word_at(input addr_t a);
        if (in_table(a)) return prog[int'((a - RESET_PC) >> 2)];
        return fill_word(a);
    endfunction

    function automatic inst_kind_e kind_at(input addr_t a);
        if (a == FAULT_PC) return KIND_FAULT;
        if (in_table(a)) return kinds[int'((a - RESET_PC) >> 2)];
        return KIND_ALU;
    endfunction

    // faulted words never redirect
    function automatic addr_t next_pc(input addr_t a);
        if (a != FAULT_PC && kind_at(a) == KIND_JAL) begin
            return a + addr_t'(jumps[int'((a - RESET_PC) >> 2)]);
        end
        return a + 32'd4;
    endfunction

    task automatic put_jal(input int idx, input int off);
        prog[idx]  = jal_word(off);
        kinds[idx] = KIND_JAL;
        jumps[idx] = off;
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i]  = fill_word(RESET_PC + addr_t'(4 * i));
            kinds[i] = KIND_ALU;
            jumps[i] = 0;
        end
        prog[1] = 32'h0000_a103;  kinds[1] = KIND_LOAD;     // lw x2, 0(x1)
        prog[2] = 32'h0020_a023;  kinds[2] = KIND_STORE;    // sw x2, 0(x1)
        prog[3] = 32'h0020_8463;  kinds[3] = KIND_BRANCH;   // beq
        prog[4] = 32'h1234_50b7;                            // lui, still alu
        prog[5] = 32'h0000_80e7;  kinds[5] = KIND_JALR;     // no redirect from jalr
        prog[6] = 32'h0000_0073;  kinds[6] = KIND_SYSTEM;   // ecall
        prog[7] = 32'h0000_0000;  kinds[7] = KIND_ILLEGAL;
        put_jal(20, 32);     // forward to 28
        put_jal(30, -32);    // back to 22
        put_jal(27, 20);     // out of the loop to 32
        put_jal(33, 64);     // faulted, must fall through
        put_jal(40, 40);     // to 50
        put_jal(52, -32);    // back to 44
        put_jal(47, 32);     // to 55, then fill words
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_kind(input string name, input inst_kind_e got, input inst_kind_e exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %s, expected %s", $time, name, got.name(),
                     exp.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_output();
        check_addr("inst_pc_o", inst_pc, exp_pc);
        check_inst("inst_o", inst_word, word_at(exp_pc));
        check_bit("inst_err_o", inst_err, exp_pc == FAULT_PC);
        check_kind("inst_kind_o", inst_kind, kind_at(exp_pc));
        exp_pc = next_pc(exp_pc);
        seen++;
    endtask

    // take n outputs, ready on the falling edge, checked before the rising edge
    task automatic collect(input int n, input bit rand_ready);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < n && idle < WAIT_LIMIT) begin
            @(negedge clock);
            inst_ready = rand_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
            if (inst_valid && inst_ready) begin
                check_output();
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < n) begin
            $display("timeout: only %0d of %0d instructions arrived", got, n);
            errors++;
        end
        @(negedge clock);
        inst_ready = 1'b0;   // nothing leaves unchecked between tests
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("%s: %0d errors, %0d instructions checked so far", name,
                 errors - errors_before, seen);
    endtask

    task automatic test_straight();
        int e0;
        e0 = errors;
        collect(8, 1'b0);
        report_test("straight-line fetch", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = errors;
        repeat (30) begin
            @(negedge clock);
            inst_ready = 1'b0;
        end
        collect(12, 1'b0);
        budget_on = 1'b0;     // jumps follow, discarded reads start here
        report_test("back-pressure", e0);
    endtask

    task automatic test_jumps();
        int e0;
        e0 = errors;
        collect(10, 1'b0);
        report_test("jump redirect", e0);
    endtask

    task automatic test_fault();
        int e0;
        e0 = errors;
        collect(4, 1'b0);
        report_test("error response", e0);
    endtask

    task automatic test_random();
        int e0;
        e0 = errors;
        @(posedge clock);
        max_delay = 5;
        collect(40, 1'b1);
        report_test("random latency", e0);
    endtask

    // AXI slave, one beat per read, decides on the falling edge
    always @(negedge clock) begin
        if (ar_ready) begin                 // address taken at the last rise
            ar_ready = 1'b0;
            busy     = 1'b1;
            r_wait   = $urandom_range(0, max_delay);
        end
        if (r_valid) begin                  // beat taken at the last rise
            r_valid = 1'b0;
            busy    = 1'b0;
        end else if (busy && r_ready) begin
            if (r_wait == 0) begin
                r_valid = 1'b1;
                r_data  = word_at(rd_addr);
                r_resp  = (rd_addr == FAULT_PC) ? 2'd2 : 2'd0;
            end else begin
                r_wait--;
            end
        end
        if (!busy && ar_valid) begin
            if (a_wait == 0) begin
                ar_ready = 1'b1;
                rd_addr  = ar_addr;
                reads++;
                a_wait   = $urandom_range(0, max_delay);   // for the next read
            end else begin
                a_wait--;
            end
        end
    end

    // queue plus the held word bound the reads in flight
    always @(posedge clock) begin
        if (budget_on && reads > seen + QUEUE_DEPTH + 1) begin
            $display("too many reads in flight: %0d issued for %0d instructions", reads, seen);
            errors++;
        end
    end

    initial begin
        int n;
        void'($urandom(SEED));
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r_data     = '0;
        r_resp     = '0;
        inst_ready = 1'b0;
        load_program();
        exp_pc = RESET_PC;
        @(negedge clock);                    // still in reset
        check_bit("ar_valid_o", ar_valid, 1'b0);
        check_bit("r_ready_o", r_ready, 1'b0);
        check_bit("inst_valid_o", inst_valid, 1'b0);
        n = 0;
        while (reset !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clock);
            n++;
        end
        if (reset !== 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end
        test_straight();
        test_backpressure();
        test_jumps();
        test_fault();
        test_random();
        $display("summary: %0d tests, %0d instructions checked, %0d errors", tests, seen,
                 errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- common/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;      // byte address of an instruction
    typedef logic [31:0] inst_t;      // one 32-bit instruction word
    typedef logic [1:0]  axi_resp_t;  // OKAY is 2'b00, anything else faults

    typedef logic [6:0]  opcode_t;    // major opcode field inst[6:0]

    // rv32 major opcodes seen by predecode
    localparam opcode_t OPC_LOAD     = 7'b000_0011;
    localparam opcode_t OPC_MISC_MEM = 7'b000_1111;
    localparam opcode_t OPC_OP_IMM   = 7'b001_0011;
    localparam opcode_t OPC_AUIPC    = 7'b001_0111;
    localparam opcode_t OPC_STORE    = 7'b010_0011;
    localparam opcode_t OPC_OP       = 7'b011_0011;
    localparam opcode_t OPC_LUI      = 7'b011_0111;
    localparam opcode_t OPC_BRANCH   = 7'b110_0011;
    localparam opcode_t OPC_JALR     = 7'b110_0111;
    localparam opcode_t OPC_JAL      = 7'b110_1111;
    localparam opcode_t OPC_SYSTEM   = 7'b111_0011;

    // instruction class handed to decode
    typedef enum logic [3:0] {
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_SYSTEM,
        KIND_ILLEGAL,
        KIND_FAULT      // bus error on the fetch
    } inst_kind_e;

    // read master states
    typedef enum logic [1:0] {
        ST_IDLE,        // waiting for a request
        ST_AR,          // address phase
        ST_R,           // data phase
        ST_HOLD         // word held for the queue
    } fetch_state_e;

endpackage

//--- common/fetch_rsp_if.sv
`timescale 1ns/1ns

// fetched word plus its pc and bus error, valid/ready handshake
interface fetch_rsp_if;
    import fetch_pkg::*;

    logic  valid;   // word on offer
    logic  ready;   // consumer takes it
    addr_t pc;      // address the word came from
    inst_t inst;    // raw instruction bits
    logic  err;     // bus returned non-OKAY

    modport producer (
        output valid, pc, inst, err,
        input  ready
    );

    modport consumer (
        input  valid, pc, inst, err,
        output ready
    );

endinterface

//--- logic/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC    = 32'h8000_0000,
    parameter int unsigned      QUEUE_DEPTH = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    // axi read master
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    output fetch_pkg::addr_t      ar_addr_o,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    input  fetch_pkg::inst_t      r_data_i,
    input  fetch_pkg::axi_resp_t  r_resp_i,
    // instructions toward decode
    output logic                  inst_valid_o,
    input  logic                  inst_ready_i,
    output fetch_pkg::addr_t      inst_pc_o,
    output fetch_pkg::inst_t      inst_o,
    output logic                  inst_err_o,
    output fetch_pkg::inst_kind_e inst_kind_o
);
    import fetch_pkg::*;

    logic  req_valid;     // pc_gen to axi_fetch
    logic  req_ready;
    addr_t req_addr;
    logic  flush;         // jal redirect pulse
    addr_t redirect_pc;

    fetch_rsp_if rsp ();  // axi_fetch to queue
    fetch_rsp_if head (); // queue to predecode

    pc_gen #(.RESET_PC(RESET_PC)) u_pc_gen (
        .clock         (clock),
        .reset         (reset),
        .req_valid_o   (req_valid),
        .req_ready_i   (req_ready),
        .req_addr_o    (req_addr),
        .flush_i       (flush),
        .redirect_pc_i (redirect_pc)
    );

    axi_fetch u_axi_fetch (
        .clock       (clock),
        .reset       (reset),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_addr_i  (req_addr),
        .flush_i     (flush),
        .ar_valid_o  (ar_valid_o),
        .ar_ready_i  (ar_ready_i),
        .ar_addr_o   (ar_addr_o),
        .r_valid_i   (r_valid_i),
        .r_ready_o   (r_ready_o),
        .r_data_i    (r_data_i),
        .r_resp_i    (r_resp_i),
        .rsp         (rsp.producer)
    );

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_inst_queue (
        .clock   (clock),
        .reset   (reset),
        .flush_i (flush),
        .push    (rsp.consumer),
        .pop     (head.producer)
    );

    predecode u_predecode (
        .head          (head.consumer),
        .inst_valid_o  (inst_valid_o),
        .inst_ready_i  (inst_ready_i),
        .inst_pc_o     (inst_pc_o),
        .inst_o        (inst_o),
        .inst_err_o    (inst_err_o),
        .inst_kind_o   (inst_kind_o),
        .flush_o       (flush),
        .redirect_pc_o (redirect_pc)
    );

endmodule

//--- logic/inst_queue.sv
`timescale 1ns/1ns

module inst_queue #(
    parameter int unsigned QUEUE_DEPTH = 4    // power of two, 2 or more
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          flush_i,   // empty on redirect
    fetch_rsp_if.consumer push,      // from axi_fetch
    fetch_rsp_if.producer pop        // head toward predecode
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // storage, no reset needed
    addr_t pc_mem   [QUEUE_DEPTH];
    inst_t inst_mem [QUEUE_DEPTH];
    logic  err_mem  [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;   // entries in use

    logic do_push;
    logic do_pop;

    assign push.ready = (count_q != CNT_W'(QUEUE_DEPTH));   // not full
    assign pop.valid  = (count_q != '0);
    assign pop.pc     = pc_mem[rd_ptr_q];
    assign pop.inst   = inst_mem[rd_ptr_q];
    assign pop.err    = err_mem[rd_ptr_q];

    assign do_push = push.valid && push.ready;
    assign do_pop  = pop.valid && pop.ready;

    always_ff @(posedge clock) begin
        if (do_push) begin
            pc_mem[wr_ptr_q]   <= push.pc;
            inst_mem[wr_ptr_q] <= push.inst;
            err_mem[wr_ptr_q]  <= push.err;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // none or both
            endcase
        end
    end

    property p_no_overflow;
        @(posedge clock) disable iff (!reset)
            count_q <= CNT_W'(QUEUE_DEPTH);
    endproperty
    a_no_overflow: assert property (p_no_overflow)
        else $error("inst_queue: count above depth");

endmodule

//--- logic/pc_gen.sv
`timescale 1ns/1ns

module pc_gen #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h8000_0000
) (
    input  logic             clock,
    input  logic             reset,
    output logic             req_valid_o,   // fetch request
    input  logic             req_ready_i,   // read master free
    output fetch_pkg::addr_t req_addr_o,    // address to fetch
    input  logic             flush_i,       // redirect from predecode
    input  fetch_pkg::addr_t redirect_pc_i  // new fetch target
);
    import fetch_pkg::*;

    addr_t pc_q;        // next address to request
    logic  running_q;   // set one cycle after reset release

    // request line stays up once out of reset
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            running_q <= 1'b0;
        end else begin
            running_q <= 1'b1;
        end
    end

    // redirect wins over a same-cycle accept
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc_q <= RESET_PC;
        end else if (flush_i) begin
            pc_q <= redirect_pc_i;          // jump target
        end else if (req_valid_o && req_ready_i) begin
            pc_q <= pc_q + 32'd4;           // sequential
        end
    end

    assign req_valid_o = running_q;
    assign req_addr_o  = pc_q;

endmodule

//--- logic/predecode.sv
`timescale 1ns/1ns

module predecode (
    fetch_rsp_if.consumer     head,           // queue head
    output logic              inst_valid_o,
    input  logic              inst_ready_i,
    output fetch_pkg::addr_t  inst_pc_o,
    output fetch_pkg::inst_t  inst_o,
    output logic              inst_err_o,
    output fetch_pkg::inst_kind_e inst_kind_o,
    output logic              flush_o,        // jal leaving, kill younger fetches
    output fetch_pkg::addr_t  redirect_pc_o   // jal target
);
    import fetch_pkg::*;

    opcode_t    opcode;
    inst_kind_e kind;
    addr_t      j_imm;     // sign-extended J-type offset

    assign opcode = head.inst[6:0];

    // J-immediate is imm[20|10:1|11|19:12] packed in inst[31:12]
    assign j_imm = {{12{head.inst[31]}}, head.inst[19:12], head.inst[20],
                    head.inst[30:21], 1'b0};

    always_comb begin
        if (head.err) begin
            kind = KIND_FAULT;      // bits are garbage, ignore opcode
        end else begin
            case (opcode)
                OPC_OP, OPC_OP_IMM,
                OPC_LUI, OPC_AUIPC:     kind = KIND_ALU;
                OPC_LOAD:               kind = KIND_LOAD;
                OPC_STORE:              kind = KIND_STORE;
                OPC_BRANCH:             kind = KIND_BRANCH;
                OPC_JAL:                kind = KIND_JAL;
                OPC_JALR:               kind = KIND_JALR;
                OPC_SYSTEM,
                OPC_MISC_MEM:           kind = KIND_SYSTEM;   // fence grouped here
                default:                kind = KIND_ILLEGAL;
            endcase
        end
    end

    // pass through, handshake is combinational
    assign inst_valid_o = head.valid;
    assign head.ready   = inst_ready_i;
    assign inst_pc_o    = head.pc;
    assign inst_o       = head.inst;
    assign inst_err_o   = head.err;
    assign inst_kind_o  = kind;

    // redirect fires only on the actual output transfer of a good jal
    assign redirect_pc_o = head.pc + j_imm;
    assign flush_o       = head.valid && inst_ready_i && (kind == KIND_JAL);

endmodule
